// File: Bender.yml
package:
  name: denseLayer

sources:
  - src/nnLayerPkg.sv
  - src/wbBusPkg.sv
  - src/layerControl.sv
  - src/inputCounter.sv
  - src/activationBuffer.sv
  - src/neuronMacArray.sv
  - src/denseLayerWb.sv
  - target: simulation
    files:
      - sim/denseLayerWb_sva.sv
      - sim/denseLayerWb_tb.sv

// File: denseLayer.f
src/nnLayerPkg.sv
src/wbBusPkg.sv
src/layerControl.sv
src/inputCounter.sv
src/activationBuffer.sv
src/neuronMacArray.sv
src/denseLayerWb.sv
sim/denseLayerWb_sva.sv
sim/denseLayerWb_tb.sv

// File: sim/denseLayerWb_sva.sv
module denseLayerWb_sva
	import wbBusPkg::*;
(
	input logic clk,
	input logic reset,
	input wbReqT wbReq,
	input wbRspT wbRsp,
	input logic startReq,
	input logic busy,
	input logic done
);

	timeunit 1ns;
	timeprecision 1ps;

	int failCount = 0;

	ackSingleCycle: assert property (@(posedge clk) disable iff (reset)
		wbRsp.ack |=> !wbRsp.ack)
		else
		begin
			$error("Acknowledge stayed high for two cycles.");
			failCount++;
		end

	ackAfterRequest: assert property (@(posedge clk) disable iff (reset)
		wbRsp.ack |-> $past(wbReq.cyc && wbReq.stb))
		else
		begin
			$error("Acknowledge without a preceding cyc and stb.");
			failCount++;
		end

	busyDoneExclusive: assert property (@(posedge clk) disable iff (reset)
		!(busy && done))
		else
		begin
			$error("Busy and done are high together.");
			failCount++;
		end

	// Clear, 30 accumulate cycles and finish, then done is visible one cycle later.
	doneAfterStart: assert property (@(posedge clk) disable iff (reset)
		(startReq && !busy) |-> ##[1:33] done)
		else
		begin
			$error("Done did not follow an accepted start.");
			failCount++;
		end

endmodule

bind denseLayerWb denseLayerWb_sva i_denseLayerWbSva (
	.clk(clk),
	.reset(reset),
	.wbReq(wbReq),
	.wbRsp(wbRsp),
	.startReq(startReq),
	.busy(busy),
	.done(done)
);

// File: sim/denseLayerWb_tb.sv
module denseLayerWb_tb
	import nnLayerPkg::*;
	import wbBusPkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int ackTimeout = 16;
	localparam int pollLimit = 64;
	localparam int randomVectors = 6;

	typedef logic [numInputs-1:0][7:0] actVecT;

	logic clk;
	logic reset;
	wbReqT wbReq;
	wbRspT wbRsp;

	actVecT shadowActs; // What the buffer should hold after the writes so far.
	logic [31:0] rngState;
	int errorCount;
	int testsRun;
	int testsFailed;

	denseLayerWb i_denseLayerWb (
		.clk(clk),
		.reset(reset),
		.wbReq(wbReq),
		.wbRsp(wbRsp)
	);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic abortRun(input string reason);
		$display("%s", reason);
		$display("TEST RESULT: FAIL");
		$finish;
	endtask

	task automatic checkEqual(input string testName, input string what,
		input logic [31:0] expected, input logic [31:0] actual);
		assert (actual === expected)
		else
		begin
			$display("ERROR %s %s expected %0d actual %0d", testName, what, expected, actual);
			errorCount++;
		end
	endtask

	// One classic cycle. The request is dropped on the edge that samples ack.
	task automatic busAccess(input logic we, input logic [4:0] adr, input logic [3:0] sel,
		input logic [31:0] wdata, output logic [31:0] rdata);
		wbReqT req;
		int waited;
		logic seen;
		req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, sel: sel, dat: wdata};
		waited = 0;
		seen = 1'b0;
		rdata = '0;
		@(posedge clk);
		wbReq <= req;
		while (!seen && waited < ackTimeout)
		begin
			@(posedge clk);
			if (wbRsp.ack)
			begin
				seen = 1'b1;
				rdata = wbRsp.dat;
			end
			waited++;
		end
		wbReq <= '0;
		if (!seen)
			abortRun($sformatf("No acknowledge within %0d cycles for address %0d.", ackTimeout, adr));
	endtask

	task automatic writeActWord(input int word, input logic [3:0] sel, input logic [31:0] data);
		logic [31:0] unused;
		busAccess(1'b1, 5'(regActBase + word), sel, data, unused);
		for (int lane = 0; lane < 4; lane++)
		begin
			if (sel[lane] && word * 4 + lane < numInputs)
				shadowActs[word * 4 + lane] = data[lane * 8 +: 8];
		end
	endtask

	task automatic loadActs(input actVecT acts);
		logic [31:0] data;
		int idx;
		for (int word = 0; word < numActWords; word++)
		begin
			data = '0;
			for (int lane = 0; lane < 4; lane++)
			begin
				idx = word * 4 + lane;
				if (idx < numInputs)
					data[lane * 8 +: 8] = acts[idx];
			end
			writeActWord(word, 4'hF, data);
		end
	endtask

	task automatic startLayer();
		logic [31:0] unused;
		busAccess(1'b1, regCtrl, 4'hF, 32'h1, unused);
	endtask

	task automatic waitDone();
		logic [31:0] status;
		int polls;
		polls = 0;
		status = '0;
		while (!status[2] && polls < pollLimit)
		begin
			busAccess(1'b0, regCtrl, 4'hF, '0, status);
			polls++;
		end
		if (!status[2])
			abortRun($sformatf("Layer did not report done after %0d status polls.", pollLimit));
	endtask

	// Signed products summed, bias added last, wrapped to 16 bits, negative results zeroed.
	function automatic resultArrT layerModel(input actVecT acts);
		resultArrT res;
		int total;
		logic [15:0] wrapped;
		for (int n = 0; n < numNeurons; n++)
		begin
			total = 0;
			for (int i = 0; i < numInputs; i++)
				total += int'($signed(acts[i])) * int'(weightTable[n][i]);
			total += int'(biasTable[n]);
			wrapped = total[15:0];
			res[n] = wrapped[15] ? 16'd0 : wrapped;
		end
		return res;
	endfunction

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic checkResults(input string testName, input resultArrT expected);
		logic [31:0] data;
		for (int n = 0; n < numNeurons; n++)
		begin
			busAccess(1'b0, 5'(regResultBase + n), 4'hF, '0, data);
			checkEqual(testName, $sformatf("result %0d", n), 32'(expected[n]), data);
		end
	endtask

	task automatic finishTest(input string testName, input int errorsBefore);
		testsRun++;
		if (errorCount == errorsBefore)
			$display("%s finished without errors", testName);
		else
		begin
			testsFailed++;
			$display("%s finished with %0d errors", testName, errorCount - errorsBefore);
		end
	endtask

	task automatic runVector(input string testName, input actVecT acts, input resultArrT expected,
		input bit checkModel);
		int errorsBefore;
		resultArrT modelRes;
		errorsBefore = errorCount;
		if (checkModel)
		begin
			modelRes = layerModel(acts);
			for (int n = 0; n < numNeurons; n++)
				checkEqual(testName, $sformatf("model result %0d", n), 32'(expected[n]),
					32'(modelRes[n]));
		end
		loadActs(acts);
		startLayer();
		waitDone();
		checkResults(testName, expected);
		finishTest(testName, errorsBefore);
	endtask

	task automatic resetTest();
		logic [31:0] status;
		int errorsBefore;
		errorsBefore = errorCount;
		busAccess(1'b0, regCtrl, 4'hF, '0, status);
		checkEqual("afterReset", "status", 32'h0, status);
		checkResults("afterReset", '0);
		finishTest("afterReset", errorsBefore);
	endtask

	task automatic runFileVectors();
		int fd;
		int code;
		int value;
		int count;
		string testName;
		string rest;
		actVecT acts;
		resultArrT expected;
		count = 0;
		fd = $fopen("sim/denseLayer_tests.txt", "r");
		if (fd == 0)
			abortRun("Could not open the test vector file sim/denseLayer_tests.txt.");
		while (!$feof(fd))
		begin
			code = $fscanf(fd, "%s", testName);
			if (code == 1 && testName.getc(0) == "#")
				code = $fgets(rest, fd); // Comment line.
			else if (code == 1)
			begin
				for (int i = 0; i < numInputs; i++)
				begin
					code = $fscanf(fd, "%d", value);
					acts[i] = value[7:0];
				end
				for (int n = 0; n < numNeurons; n++)
				begin
					code = $fscanf(fd, "%d", value);
					expected[n] = value[15:0];
				end
				if (code != 1)
					abortRun($sformatf("Test vector %s in the data file is incomplete.", testName));
				runVector(testName, acts, expected, 1'b1);
				count++;
			end
		end
		$fclose(fd);
		assert (count > 0)
		else
		begin
			$display("No test vectors were read from the data file.");
			errorCount++;
		end
	endtask

	task automatic byteSelectTest();
		actVecT acts;
		int errorsBefore;
		errorsBefore = errorCount;
		for (int i = 0; i < numInputs; i++)
			acts[i] = 8'd1;
		loadActs(acts);
		writeActWord(0, 4'b0101, 32'h05060708);
		writeActWord(7, 4'b1100, 32'h7F7F0000); // Both lanes lie past input 29.
		writeActWord(7, 4'b0010, 32'h0000F600);
		startLayer();
		waitDone();
		checkResults("byteSelect", layerModel(shadowActs));
		finishTest("byteSelect", errorsBefore);
	endtask

	task automatic busyIgnoreTest();
		actVecT acts;
		logic [31:0] status;
		logic [31:0] unused;
		int errorsBefore;
		errorsBefore = errorCount;
		for (int i = 0; i < numInputs; i++)
			acts[i] = 8'(i - 15);
		loadActs(acts);
		startLayer();
		busAccess(1'b0, regCtrl, 4'hF, '0, status);
		checkEqual("busyIgnore", "status while busy", 32'h2, status);
		busAccess(1'b1, regActBase, 4'hF, 32'h7F7F7F7F, unused);
		busAccess(1'b1, 5'(regActBase + 7), 4'hF, 32'h80808080, unused);
		startLayer();
		waitDone();
		checkResults("busyIgnore", layerModel(shadowActs));
		busAccess(1'b0, regCtrl, 4'hF, '0, status);
		checkEqual("busyIgnore", "status after run", 32'h4, status);
		// A fresh run shows whether the buffer was touched while busy.
		startLayer();
		waitDone();
		checkResults("busyIgnore", layerModel(shadowActs));
		finishTest("busyIgnore", errorsBefore);
	endtask

	task automatic randomTests();
		actVecT acts;
		for (int v = 0; v < randomVectors; v++)
		begin
			for (int i = 0; i < numInputs; i++)
			begin
				rngState = xorshift(rngState);
				acts[i] = rngState[7:0];
			end
			runVector($sformatf("random%0d", v), acts, layerModel(acts), 1'b0);
		end
	endtask

	initial
	begin
		errorCount = 0;
		testsRun = 0;
		testsFailed = 0;
		rngState = 32'h890f;
		shadowActs = '0;
		reset = 1'b1;
		wbReq = '0;
		repeat (5) @(posedge clk);
		reset <= 1'b0;

		resetTest();
		runFileVectors();
		byteSelectTest();
		busyIgnoreTest();
		randomTests();

		$display("%0d tests run, %0d failed, %0d check errors, %0d assertion failures",
			testsRun, testsFailed, errorCount, i_denseLayerWb.i_denseLayerWbSva.failCount);
		if (errorCount == 0 && i_denseLayerWb.i_denseLayerWbSva.failCount == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

// File: sim/denseLayer_tests.txt
# name, then activations 0 to 29 as signed decimals, then results of neurons 0 to 3
# results are 16-bit wrapped sums plus bias, zero when bit 15 is set
zeros 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 14 0 35 0
bit7Set 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 606 237 241 296
allTwos 2 2 2 2 2 2 2 2 2 2 2 2 2 2 2 2 2 2 2 2 2 2 2 2 2 2 2 2 2 2 1198 483 447 612
allMinusOne -1 -1 -1 -1 -1 -1 -1 -1 -1 -1 -1 -1 -1 -1 -1 -1 -1 -1 -1 -1 -1 -1 -1 -1 -1 -1 -1 -1 -1 -1 0 0 0 0
allMax 127 127 127 127 127 127 127 127 127 127 127 127 127 127 127 127 127 127 127 127 127 127 127 127 127 127 127 127 127 127 9662 31233 26197 0
allMin -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 0 0 0 25068
all64 64 64 64 64 64 64 64 64 64 64 64 64 64 64 64 64 64 64 64 64 64 64 64 64 64 64 64 64 64 64 0 15735 13219 20204
all100 100 100 100 100 100 100 100 100 100 100 100 100 100 100 100 100 100 100 100 100 100 100 100 100 100 100 100 100 100 100 0 24591 20635 31580
unit0 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 12 0 44
unit7 0 0 0 0 0 0 0 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 130 46 37 0
unit29 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 0 0 57 0
neg28 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 -5 0 0 0 55 0
max4 0 0 0 0 127 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 4967 1134 12862 0
firstTen 1 1 1 1 1 1 1 1 1 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 170 74 124 93
midMinus 0 0 0 0 0 0 0 0 0 0 -1 -1 -1 -1 -1 -1 -1 -1 -1 -1 0 0 0 0 0 0 0 0 0 0 0 0 3 0
lastThrees 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 3 3 3 3 3 3 3 3 3 3 524 147 290 181
mixed 1 1 1 1 1 1 1 1 1 1 2 2 2 2 2 2 2 2 2 2 -3 -3 -3 -3 -3 -3 -3 -3 -3 -3 192 140 0 164

// File: src/activationBuffer.sv
module activationBuffer
	import nnLayerPkg::*;
	import wbBusPkg::*;
(
	input logic clk,
	input logic reset,
	input logic writeEn,
	input logic [2:0] wordIndex,
	input logic [3:0] byteSel,
	input wbDataU writeData,
	input idxT readIndex,
	output actT activation
);

	actT acts [numInputs];

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			acts <= '{default: '0};
		end
		else if (writeEn)
		begin
			for (int lane = 0; lane < 4; lane++)
			begin
				// The last word has two lanes past the end of the buffer.
				if (byteSel[lane] && (int'(wordIndex) * 4 + lane < numInputs))
					acts[int'(wordIndex) * 4 + lane] <= writeData.act[lane];
			end
		end
	end

	// The counter passes the end of the range once accumulation is over.
	assign activation = (readIndex < idxT'(numInputs)) ? acts[readIndex] : '0;

endmodule

// File: src/denseLayerWb.sv
module denseLayerWb
	import nnLayerPkg::*;
	import wbBusPkg::*;
(
	input logic clk,
	input logic reset,
	input wbReqT wbReq,
	output wbRspT wbRsp
);

	logic ack;
	logic writeStrobe;
	logic isActWord;
	logic isResultWord;
	logic [1:0] resultIndex;
	wbDataU wrWord;
	wbDataU rdWord;

	logic startReq;
	logic actWriteEn;
	logic clearAcc;
	logic accEnable;
	logic finish;
	logic countClear;
	logic countEnable;
	logic busy;
	logic done;
	logic lastInput;
	idxT index;
	actT activation;
	resultArrT results;

	// Every access is acknowledged one cycle after it is seen.
	always_ff @(posedge clk)
	begin
		if (reset)
			ack <= 1'b0;
		else
			ack <= wbReq.cyc && wbReq.stb && !ack;
	end

	assign wrWord = wbReq.dat;
	assign writeStrobe = wbReq.cyc && wbReq.stb && wbReq.we && ack;
	assign isActWord = (wbReq.adr >= regActBase) && (wbReq.adr < regActBase + numActWords);
	assign isResultWord = (wbReq.adr >= regResultBase) &&
		(wbReq.adr < regResultBase + numNeurons);
	assign resultIndex = 2'(wbReq.adr - regResultBase);

	assign startReq = writeStrobe && (wbReq.adr == regCtrl) && wrWord.ctrl.start;
	assign actWriteEn = writeStrobe && isActWord && !busy; // Buffer is frozen while busy.

	always_comb
	begin
		rdWord.raw = '0; // Unmapped words read as zero.
		if (wbReq.adr == regCtrl)
		begin
			rdWord.ctrl.busy = busy;
			rdWord.ctrl.done = done;
		end
		else if (isResultWord)
			rdWord.raw = 32'(results[resultIndex]);
	end

	assign wbRsp.ack = ack;
	assign wbRsp.dat = ack ? rdWord.raw : '0;

	layerControl i_layerControl (
		.clk(clk),
		.reset(reset),
		.startReq(startReq),
		.lastInput(lastInput),
		.clearAcc(clearAcc),
		.accEnable(accEnable),
		.finish(finish),
		.countClear(countClear),
		.countEnable(countEnable),
		.busy(busy),
		.done(done)
	);

	inputCounter i_inputCounter (
		.clk(clk),
		.reset(reset),
		.countClear(countClear),
		.countEnable(countEnable),
		.index(index),
		.lastInput(lastInput)
	);

	activationBuffer i_activationBuffer (
		.clk(clk),
		.reset(reset),
		.writeEn(actWriteEn),
		.wordIndex(3'(wbReq.adr - regActBase)),
		.byteSel(wbReq.sel),
		.writeData(wrWord),
		.readIndex(index),
		.activation(activation)
	);

	neuronMacArray i_neuronMacArray (
		.clk(clk),
		.reset(reset),
		.clearAcc(clearAcc),
		.accEnable(accEnable),
		.finish(finish),
		.index(index),
		.activation(activation),
		.results(results)
	);

endmodule

// File: src/inputCounter.sv
module inputCounter
	import nnLayerPkg::*;
(
	input logic clk,
	input logic reset,
	input logic countClear,
	input logic countEnable,
	output idxT index,
	output logic lastInput
);

	always_ff @(posedge clk)
	begin
		if (reset)
			index <= '0;
		else if (countClear)
			index <= '0;
		else if (countEnable)
			index <= index + idxT'(1);
	end

	// High while the final input is being accumulated.
	assign lastInput = (index == idxT'(numInputs - 1));

endmodule

// File: src/layerControl.sv
module layerControl (
	input logic clk,
	input logic reset,
	input logic startReq,
	input logic lastInput,
	output logic clearAcc,
	output logic accEnable,
	output logic finish,
	output logic countClear,
	output logic countEnable,
	output logic busy,
	output logic done
);

	typedef enum logic [1:0] {
		stateIdle,
		stateClear,
		stateAccumulate,
		stateFinish
	} stateT;

	stateT state;
	stateT stateNext;

	always_comb
	begin
		stateNext = state;
		case (state)
			stateIdle:
			begin
				if (startReq)
					stateNext = stateClear; // Starts anywhere else are ignored.
			end
			stateClear:
				stateNext = stateAccumulate;
			stateAccumulate:
			begin
				if (lastInput)
					stateNext = stateFinish;
			end
			stateFinish:
				stateNext = stateIdle;
			default:
				stateNext = stateIdle;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= stateIdle;
			done <= 1'b0;
		end
		else
		begin
			state <= stateNext;
			// Done holds from the finish cycle until the next accepted start.
			if (state == stateFinish)
				done <= 1'b1;
			else if (state == stateIdle && startReq)
				done <= 1'b0;
		end
	end

	assign clearAcc = (state == stateClear);
	assign countClear = (state == stateClear);
	assign accEnable = (state == stateAccumulate);
	assign countEnable = (state == stateAccumulate);
	assign finish = (state == stateFinish);
	assign busy = (state != stateIdle); // Falls in the same cycle that done rises.

endmodule

// File: src/neuronMacArray.sv
module neuronMacArray
	import nnLayerPkg::*;
(
	input logic clk,
	input logic reset,
	input logic clearAcc,
	input logic accEnable,
	input logic finish,
	input idxT index,
	input actT activation,
	output resultArrT results
);

	accT acc [numNeurons];
	accT products [numNeurons];
	accT biased [numNeurons];

	always_comb
	begin
		for (int n = 0; n < numNeurons; n++)
		begin
			// Signed 8 by 8 product, widened before the multiply.
			products[n] = accT'(activation) * accT'(weightTable[n][index]);
			biased[n] = acc[n] + accT'(biasTable[n]);
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			acc <= '{default: '0};
			results <= '0;
		end
		else
		begin
			for (int n = 0; n < numNeurons; n++)
			begin
				if (clearAcc)
					acc[n] <= '0;
				else if (accEnable)
					acc[n] <= acc[n] + products[n]; // Wraps in 16 bits.

				// Rectifier on the sign of the full 16-bit sum.
				if (finish)
					results[n] <= biased[n][15] ? 16'd0 : 16'(biased[n]);
			end
		end
	end

endmodule

// File: src/nnLayerPkg.sv
package nnLayerPkg;

	localparam int numInputs = 30;
	localparam int numNeurons = 4;

	typedef logic [4:0] idxT;
	typedef logic signed [7:0] actT;
	typedef logic signed [15:0] accT; // Sums wrap in 16 bits.

	// Results as seen on the bus, neuron 0 in the low word.
	typedef logic [numNeurons-1:0][15:0] resultArrT;

	// One row per neuron, one entry per input. Row 0 is the reference neuron.
	localparam actT weightTable [numNeurons][numInputs] = '{
		'{
			-13, -33, -13, 39, 39, 4, -50, 116, 3, 64,
			18, -23, 27, 69, 24, 43, -47, 72, 20, 63,
			62, 39, 15, -76, 54, 19, 55, -32, 62, -28
		},
		'{
			21, -7, 44, -61, 9, 30, -18, 55, -2, 12,
			71, -40, 5, 33, -25, 48, -11, 6, 90, -66,
			14, -3, 27, 39, -52, 8, 60, -19, 23, -45
		},
		'{
			-80, 15, 3, -27, 101, -6, 37, 2, -14, 58,
			-33, 19, 26, -71, 44, -8, 12, 67, -29, 5,
			-42, 88, -17, 31, 9, -55, 13, 40, -4, 22
		},
		'{
			64, 64, -32, 17, -100, 45, 11, -23, 76, -9,
			28, 53, -61, 7, 19, -38, 95, -12, 4, 41,
			-77, 26, 10, -15, 83, 36, -48, 1, 57, -6
		}
	};

	// Added after the last product, sign-extended to the accumulator width.
	localparam actT biasTable [numNeurons] = '{14, -9, 35, -20};

endpackage

// File: src/wbBusPkg.sv
package wbBusPkg;

	import nnLayerPkg::*;

	// Word addresses.
	localparam logic [4:0] regCtrl = 5'd0;
	localparam logic [4:0] regActBase = 5'd1;
	localparam logic [4:0] regResultBase = 5'd16;
	localparam int numActWords = 8; // Word 8 carries only inputs 28 and 29.

	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		logic [4:0] adr;
		logic [3:0] sel;
		logic [31:0] dat;
	} wbReqT;

	typedef struct packed {
		logic ack;
		logic [31:0] dat;
	} wbRspT;

	// Start is only meaningful on a write, busy and done only on a read.
	typedef struct packed {
		logic [28:0] reserved;
		logic done;
		logic busy;
		logic start;
	} ctrlStatusT;

	typedef union packed {
		logic [31:0] raw;
		actT [3:0] act; // Lane 0 is the low byte.
		ctrlStatusT ctrl;
	} wbDataU;

endpackage
